// File: rtl/audio_cfg.svh
`ifndef AUDIO_CFG_SVH
`define AUDIO_CFG_SVH

// Phase accumulator width
`define PHASE_W 30

// Audio sample width
`define SAMPLE_W 16

// Quarter-wave table address width, 256 entries
`define TABLE_AW 8

// i_clk cycles per bit clock half-period
`define SCLK_DIV 2

// Bits per channel slot
`define SLOT_W 32

`define GAIN_FRAC 14 // 16'h4000 is unity gain

`endif

// File: rtl/synth_pkg.sv
`include "audio_cfg.svh"

package synth_pkg;

    // Waveform selector per voice
    typedef enum logic [1:0] {
        WAVE_SAW    = 2'd0,
        WAVE_SQUARE = 2'd1,
        WAVE_SINE   = 2'd2
    } wave_t;

    typedef logic signed [`SAMPLE_W-1:0] sample_t;

endpackage

// File: rtl/i2s_pkg.sv
`include "audio_cfg.svh"

package i2s_pkg;

    // Word clock level, low is left
    typedef enum logic {
        CHAN_LEFT  = 1'b0,
        CHAN_RIGHT = 1'b1
    } chan_t;

    typedef logic [`SLOT_W-1:0] slot_t;

endpackage

// File: rtl/ddfs_voice.sv
`timescale 1ns/1ps
`include "audio_cfg.svh"

module ddfs_voice (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_frame,
    input  logic [`PHASE_W-1:0]   i_fccw,
    input  synth_pkg::wave_t      i_wave,
    input  logic [15:0]           i_gain,
    input  logic                  i_ack,
    input  synth_pkg::sample_t    i_tbl_data,
    output logic                  o_req,
    output logic [`TABLE_AW-1:0]  o_tbl_addr,
    output synth_pkg::sample_t    o_sample
);
    import synth_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_DROP
    } state_t;

    localparam int PROD_W = `SAMPLE_W + 17;
    localparam logic signed [PROD_W-1:0] SAT_HI = (2 ** (`SAMPLE_W - 1)) - 1;
    localparam logic signed [PROD_W-1:0] SAT_LO = -SAT_HI;
    localparam sample_t FULL_SCALE = sample_t'(SAT_HI);

    state_t                    state;
    logic [`PHASE_W-1:0]       phase;
    logic [`PHASE_W-1:0]       phase_nxt;
    logic [`TABLE_AW-1:0]      fold_addr;
    logic                      neg_q;
    logic                      rdy;
    sample_t                   raw_q;
    sample_t                   flat_sample;
    logic signed [PROD_W-1:0]  prod;
    logic signed [PROD_W-1:0]  scaled;
    sample_t                   gained;

    assign phase_nxt = phase + i_fccw;

    // Second quadrant bit mirrors the address
    assign fold_addr = phase_nxt[`PHASE_W-2] ? ~phase_nxt[`PHASE_W-3 -: `TABLE_AW]
                                             : phase_nxt[`PHASE_W-3 -: `TABLE_AW];

    always_comb begin
        case (i_wave)
            WAVE_SAW: flat_sample = sample_t'(phase_nxt[`PHASE_W-1 -: `SAMPLE_W]);
            default:  flat_sample = phase_nxt[`PHASE_W-1] ? -FULL_SCALE : FULL_SCALE;
        endcase
    end

    // Gain is unsigned Q2.14
    assign prod   = raw_q * $signed({1'b0, i_gain});
    assign scaled = prod >>> `GAIN_FRAC;
    assign gained = (scaled > SAT_HI) ? FULL_SCALE :
                    (scaled < SAT_LO) ? -FULL_SCALE : sample_t'(scaled);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state      <= S_IDLE;
            phase      <= '0;
            o_req      <= 1'b0;
            o_tbl_addr <= '0;
            neg_q      <= 1'b0;
            raw_q      <= '0;
            rdy        <= 1'b0;
            o_sample   <= '0;
        end else begin
            rdy <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_frame) begin
                        phase <= phase_nxt;
                        if (i_wave == WAVE_SINE) begin
                            o_req      <= 1'b1;
                            o_tbl_addr <= fold_addr;
                            neg_q      <= phase_nxt[`PHASE_W-1]; // Lower half cycle
                            state      <= S_REQ;
                        end else begin
                            raw_q <= flat_sample;
                            rdy   <= 1'b1;
                        end
                    end
                end
                S_REQ: begin
                    if (i_ack) begin
                        o_req <= 1'b0;
                        raw_q <= neg_q ? -i_tbl_data : i_tbl_data;
                        rdy   <= 1'b1;
                        state <= S_DROP;
                    end
                end
                S_DROP: begin
                    if (!i_ack)
                        state <= S_IDLE; // Four-phase return
                end
                default: state <= S_IDLE;
            endcase
            if (rdy)
                o_sample <= gained;
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_req) |-> !i_ack)
        else $error("table request raised while ack still high");

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_req && $past(o_req) |-> $stable(o_tbl_addr))
        else $error("table address moved during request");

endmodule

// File: rtl/sine_table_arbiter.sv
`timescale 1ns/1ps
`include "audio_cfg.svh"

module sine_table_arbiter (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_req0,
    input  logic [`TABLE_AW-1:0]  i_addr0,
    input  logic                  i_req1,
    input  logic [`TABLE_AW-1:0]  i_addr1,
    output logic                  o_ack0,
    output logic                  o_ack1,
    output synth_pkg::sample_t    o_data
);
    import synth_pkg::*;

    localparam int  TABLE_N = 1 << `TABLE_AW;
    localparam real PI      = 3.14159265358979;
    localparam real AMP     = (2.0 ** (`SAMPLE_W - 1)) - 1.0;

    typedef sample_t table_t [TABLE_N];

    // Quarter wave, sampled at bin centres
    function automatic table_t build_table();
        table_t tbl;
        real    ang;
        for (int n = 0; n < TABLE_N; n++) begin
            ang    = (n + 0.5) * PI / (2.0 * TABLE_N);
            tbl[n] = sample_t'($rtoi(AMP * $sin(ang) + 0.5));
        end
        return tbl;
    endfunction

    localparam table_t SINE_TBL = build_table();

    logic last1; // Voice 1 served last
    logic busy;
    logic pick1;

    assign busy  = o_ack0 || o_ack1;
    assign pick1 = i_req1 && (!i_req0 || !last1);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ack0 <= 1'b0;
            o_ack1 <= 1'b0;
            last1  <= 1'b0;
        end else if (busy) begin
            // Hold ack until the granted req drops
            if (o_ack0 && !i_req0)
                o_ack0 <= 1'b0;
            if (o_ack1 && !i_req1)
                o_ack1 <= 1'b0;
        end else if (pick1) begin
            o_ack1 <= 1'b1;
            last1  <= 1'b1;
        end else if (i_req0) begin
            o_ack0 <= 1'b1;
            last1  <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy)
            o_data <= SINE_TBL[pick1 ? i_addr1 : i_addr0];
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_ack0 && o_ack1))
        else $error("both voices granted the table");

endmodule

// File: rtl/i2s_tx.sv
`timescale 1ns/1ps
`include "audio_cfg.svh"

module i2s_tx (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  synth_pkg::sample_t  i_left,
    input  synth_pkg::sample_t  i_right,
    output logic                o_sclk,
    output logic                o_lrclk,
    output logic                o_tx_sd,
    output logic                o_frame
);
    import i2s_pkg::*;

    localparam int DIV_W = ($clog2(`SCLK_DIV) > 0) ? $clog2(`SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(2 * `SLOT_W);

    logic [DIV_W-1:0]       div_cnt;
    logic                   div_wrap;
    logic                   sclk_fall;
    logic [BIT_W-1:0]       bit_cnt;
    logic [BIT_W-1:0]       bit_nxt;
    chan_t                  lr_q;
    slot_t                  slot_l;
    slot_t                  slot_r;
    logic [2*`SLOT_W-1:0]   shreg;

    assign div_wrap  = (div_cnt == DIV_W'(`SCLK_DIV - 1));
    assign sclk_fall = div_wrap && o_sclk;
    assign bit_nxt   = bit_cnt + 1'b1;

    // Samples left aligned, zero padded
    assign slot_l = {i_left, {(`SLOT_W - `SAMPLE_W){1'b0}}};
    assign slot_r = {i_right, {(`SLOT_W - `SAMPLE_W){1'b0}}};

    assign o_lrclk = lr_q;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
            o_sclk  <= 1'b0;
        end else if (div_wrap) begin
            div_cnt <= '0;
            o_sclk  <= ~o_sclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bit_cnt <= '1; // First falling edge opens a frame
            lr_q    <= CHAN_RIGHT;
            o_frame <= 1'b0;
            o_tx_sd <= 1'b0;
            shreg   <= '0;
        end else begin
            o_frame <= 1'b0;
            if (sclk_fall) begin
                bit_cnt <= bit_nxt;
                lr_q    <= chan_t'(bit_nxt[BIT_W-1]);
                // Last bit of the old frame goes out as the new one loads
                o_tx_sd <= shreg[2*`SLOT_W-1];
                if (bit_cnt == '1) begin
                    o_frame <= 1'b1;
                    shreg   <= {slot_l, slot_r};
                end else begin
                    shreg <= shreg << 1;
                end
            end
        end
    end

endmodule

// File: rtl/i2s_rx.sv
`timescale 1ns/1ps
`include "audio_cfg.svh"

module i2s_rx (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_sclk,
    input  logic                i_lrclk,
    input  logic                i_sd,
    output synth_pkg::sample_t  o_left,
    output synth_pkg::sample_t  o_right,
    output logic                o_valid
);
    import i2s_pkg::*;

    logic   sclk_q;
    logic   sclk_rise;
    logic   boundary;
    chan_t  ws_q;     // Channel of the bit being captured
    slot_t  shreg;
    slot_t  slot_w;

    assign sclk_rise = i_sclk && !sclk_q;
    assign boundary  = sclk_rise && (chan_t'(i_lrclk) != ws_q);
    assign slot_w    = {shreg[`SLOT_W-2:0], i_sd};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sclk_q  <= 1'b0;
            ws_q    <= CHAN_RIGHT;
            shreg   <= '0;
            o_left  <= '0;
            o_right <= '0;
            o_valid <= 1'b0;
        end else begin
            sclk_q  <= i_sclk;
            o_valid <= 1'b0;
            if (sclk_rise) begin
                shreg <= slot_w;
                ws_q  <= chan_t'(i_lrclk);
                // One-bit delay puts the slot LSB after the word clock edge
                if (boundary) begin
                    if (ws_q == CHAN_RIGHT) begin
                        o_right <= slot_w[`SLOT_W-1 -: `SAMPLE_W];
                        o_valid <= 1'b1;
                    end else begin
                        o_left <= slot_w[`SLOT_W-1 -: `SAMPLE_W];
                    end
                end
            end
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |=> !o_valid)
        else $error("rx valid held for more than one cycle");

endmodule

// File: rtl/audio_top.sv
`timescale 1ns/1ps
`include "audio_cfg.svh"

module audio_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [`PHASE_W-1:0]   i_fccw0,
    input  logic [`PHASE_W-1:0]   i_fccw1,
    input  synth_pkg::wave_t      i_wave0,
    input  synth_pkg::wave_t      i_wave1,
    input  logic [15:0]           i_gain0,
    input  logic [15:0]           i_gain1,
    input  logic                  i_rx_sd,
    output logic                  o_sclk,
    output logic                  o_lrclk,
    output logic                  o_tx_sd,
    output synth_pkg::sample_t    o_rx_l,
    output synth_pkg::sample_t    o_rx_r,
    output logic                  o_rx_valid
);
    import synth_pkg::*;

    logic                  frame;
    logic                  req0;
    logic                  req1;
    logic                  ack0;
    logic                  ack1;
    logic [`TABLE_AW-1:0]  addr0;
    logic [`TABLE_AW-1:0]  addr1;
    sample_t               tbl_data;
    sample_t               sample0;
    sample_t               sample1;

    // Voice 0 is the left channel
    ddfs_voice voice0_unit (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_frame(frame),
        .i_fccw(i_fccw0),
        .i_wave(i_wave0),
        .i_gain(i_gain0),
        .i_ack(ack0),
        .i_tbl_data(tbl_data),
        .o_req(req0),
        .o_tbl_addr(addr0),
        .o_sample(sample0)
    );

    ddfs_voice voice1_unit (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_frame(frame),
        .i_fccw(i_fccw1),
        .i_wave(i_wave1),
        .i_gain(i_gain1),
        .i_ack(ack1),
        .i_tbl_data(tbl_data),
        .o_req(req1),
        .o_tbl_addr(addr1),
        .o_sample(sample1)
    );

    sine_table_arbiter arbiter_unit (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_req0(req0),
        .i_addr0(addr0),
        .i_req1(req1),
        .i_addr1(addr1),
        .o_ack0(ack0),
        .o_ack1(ack1),
        .o_data(tbl_data)
    );

    i2s_tx tx_unit (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_left(sample0),
        .i_right(sample1),
        .o_sclk(o_sclk),
        .o_lrclk(o_lrclk),
        .o_tx_sd(o_tx_sd),
        .o_frame(frame)
    );

    // Receiver runs off the transmitter's clocks
    i2s_rx rx_unit (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_sclk(o_sclk),
        .i_lrclk(o_lrclk),
        .i_sd(i_rx_sd),
        .o_left(o_rx_l),
        .o_right(o_rx_r),
        .o_valid(o_rx_valid)
    );

endmodule

// File: verif/tb_audio_top.sv
`timescale 1ns/1ps
`include "audio_cfg.svh"

module tb_audio_top;
    import synth_pkg::*;

    localparam int HALF_PERIOD  = 2;
    localparam int FRAME_CYCLES = 2 * `SLOT_W * 2 * `SCLK_DIV;
    localparam int TOTAL_FRAMES = 86; // Reset, sine, square, saw and two gain runs
    localparam int WATCHDOG_NS  = TOTAL_FRAMES * FRAME_CYCLES * 2 * HALF_PERIOD * 2;
    localparam int FULL         = (1 << (`SAMPLE_W - 1)) - 1;
    localparam real PI          = 3.14159265358979;
    localparam logic [15:0] UNITY = 16'h4000;
    localparam logic [`PHASE_W-1:0] FCCW_QUARTER = {2'b01, {(`PHASE_W - 2){1'b0}}};
    localparam logic [`PHASE_W-1:0] FCCW_SLOW    = {4'b0001, {(`PHASE_W - 4){1'b0}}};

    logic                 i_clk;
    logic                 i_rst_n;
    logic [`PHASE_W-1:0]  i_fccw0;
    logic [`PHASE_W-1:0]  i_fccw1;
    wave_t                i_wave0;
    wave_t                i_wave1;
    logic [15:0]          i_gain0;
    logic [15:0]          i_gain1;
    logic                 i_rx_sd;
    logic                 o_sclk;
    logic                 o_lrclk;
    logic                 o_tx_sd;
    sample_t              o_rx_l;
    sample_t              o_rx_r;
    logic                 o_rx_valid;

    int                   seed = 32'h94e0;
    logic [`PHASE_W-1:0]  model_ph0;
    logic [`PHASE_W-1:0]  model_ph1;
    int                   exp_l_q[$]; // Two frames of pipeline per channel
    int                   exp_r_q[$];

    audio_top i_audio_top (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_fccw0(i_fccw0),
        .i_fccw1(i_fccw1),
        .i_wave0(i_wave0),
        .i_wave1(i_wave1),
        .i_gain0(i_gain0),
        .i_gain1(i_gain1),
        .i_rx_sd(i_rx_sd),
        .o_sclk(o_sclk),
        .o_lrclk(o_lrclk),
        .o_tx_sd(o_tx_sd),
        .o_rx_l(o_rx_l),
        .o_rx_r(o_rx_r),
        .o_rx_valid(o_rx_valid)
    );

    assign i_rx_sd = o_tx_sd; // Serial loopback

    always #HALF_PERIOD i_clk = ~i_clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish in time");
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            $display("Errors found");
            $fatal(1, "check failed in %s", name);
        end
    endtask

    // Table entry n sits at the centre of its bin
    function automatic int sine_entry(input int idx);
        real ang;
        ang = (real'(idx) + 0.5) * PI / (2.0 * real'(1 << `TABLE_AW));
        return $rtoi(real'(FULL) * $sin(ang) + 0.5);
    endfunction

    function automatic int voice_sample(input logic [`PHASE_W-1:0] ph, input wave_t w,
                                        input logic [15:0] g);
        int     raw;
        int     idx;
        int     res;
        longint prod;
        case (w)
            WAVE_SQUARE: raw = ph[`PHASE_W-1] ? -FULL : FULL;
            WAVE_SINE: begin
                idx = int'(ph[`PHASE_W-3 -: `TABLE_AW]);
                if (ph[`PHASE_W-2])
                    idx = (1 << `TABLE_AW) - 1 - idx; // Falling quarter
                raw = ph[`PHASE_W-1] ? -sine_entry(idx) : sine_entry(idx);
            end
            default: raw = int'($signed(ph[`PHASE_W-1 -: `SAMPLE_W]));
        endcase
        prod = (longint'(raw) * longint'(g)) >>> `GAIN_FRAC;
        if (prod > longint'(FULL))
            res = FULL;
        else if (prod < -longint'(FULL))
            res = -FULL;
        else
            res = int'(prod);
        return res;
    endfunction

    function automatic logic [`PHASE_W-1:0] random_fccw();
        int r;
        r = $random(seed);
        return {r[`SAMPLE_W-1:0], {(`PHASE_W - `SAMPLE_W){1'b0}}};
    endfunction

    // Lands well after the strobe and any table handshake
    task automatic apply_controls(input logic [`PHASE_W-1:0] f0, input logic [`PHASE_W-1:0] f1,
                                  input wave_t w0, input wave_t w1,
                                  input logic [15:0] g0, input logic [15:0] g1);
        repeat (16) @(posedge i_clk);
        i_fccw0 <= f0;
        i_fccw1 <= f1;
        i_wave0 <= w0;
        i_wave1 <= w1;
        i_gain0 <= g0;
        i_gain1 <= g1;
    endtask

    task automatic next_frame(input string name, input bit do_check);
        int wait_cycles;
        int exp_l;
        int exp_r;
        wait_cycles = 0;
        do begin
            @(posedge i_clk);
            wait_cycles++;
            if (wait_cycles > 2 * FRAME_CYCLES) begin
                $display("No receiver valid pulse within two frames in %s", name);
                $display("Errors found");
                $fatal(1, "receiver stalled");
            end
        end while (!o_rx_valid);
        model_ph0 = model_ph0 + i_fccw0;
        model_ph1 = model_ph1 + i_fccw1;
        exp_l_q.push_back(voice_sample(model_ph0, i_wave0, i_gain0));
        exp_r_q.push_back(voice_sample(model_ph1, i_wave1, i_gain1));
        exp_l = exp_l_q.pop_front();
        exp_r = exp_r_q.pop_front();
        if (do_check) begin
            check_value({name, " left"}, exp_l, int'(o_rx_l));
            check_value({name, " right"}, exp_r, int'(o_rx_r));
        end
    endtask

    task automatic run_frames(input string name, input int count);
        next_frame(name, 1'b0);
        next_frame(name, 1'b0);
        for (int i = 0; i < count; i++)
            next_frame(name, 1'b1);
    endtask

    task automatic test_reset;
        repeat (5) @(posedge i_clk);
        check_value("reset sclk", 0, int'(o_sclk));
        check_value("reset lrclk", 1, int'(o_lrclk));
        check_value("reset tx_sd", 0, int'(o_tx_sd));
        check_value("reset rx_valid", 0, int'(o_rx_valid));
        i_rst_n <= 1'b1;
        for (int i = 0; i < 4; i++)
            next_frame("reset", 1'b1);
    endtask

    task automatic test_sine;
        apply_controls(FCCW_QUARTER, FCCW_QUARTER, WAVE_SINE, WAVE_SINE, UNITY, UNITY);
        run_frames("sine", 12);
    endtask

    task automatic test_square;
        apply_controls(FCCW_SLOW, FCCW_SLOW, WAVE_SQUARE, WAVE_SQUARE, UNITY, UNITY);
        run_frames("square", 20);
    endtask

    task automatic test_saw;
        apply_controls(random_fccw(), random_fccw(), WAVE_SAW, WAVE_SAW, UNITY, UNITY);
        run_frames("saw", 16);
    endtask

    task automatic test_gain;
        apply_controls(random_fccw(), random_fccw(), WAVE_SAW, WAVE_SAW, 16'h2000, 16'h7fff);
        run_frames("gain half", 12);
        apply_controls(random_fccw(), random_fccw(), WAVE_SAW, WAVE_SAW, 16'h7fff, 16'h2000);
        run_frames("gain full", 12);
    endtask

    initial begin
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        i_fccw0   = '0;
        i_fccw1   = '0;
        i_wave0   = WAVE_SAW;
        i_wave1   = WAVE_SAW;
        i_gain0   = UNITY;
        i_gain1   = UNITY;
        model_ph0 = '0;
        model_ph1 = '0;
        // Reset contents of the voice and shift registers
        exp_l_q.push_back(0);
        exp_l_q.push_back(0);
        exp_r_q.push_back(0);
        exp_r_q.push_back(0);
        test_reset();
        test_sine();   // Phase still aligned from reset
        test_square();
        test_saw();
        test_gain();
        $display("No errors");
        $finish;
    end

endmodule

// File: audio_top.f
+incdir+rtl
rtl/synth_pkg.sv
rtl/i2s_pkg.sv
rtl/ddfs_voice.sv
rtl/sine_table_arbiter.sv
rtl/i2s_tx.sv
rtl/i2s_rx.sv
rtl/audio_top.sv
verif/tb_audio_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the audio_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_audio_top
LOG=sim.log
FAIL_MSG="Errors found"

verilator --binary --timing --assert -f audio_top.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

# The log decides pass or fail
if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

echo "Simulation PASSED"
exit 0
